/* mmu_cfg_pkg.sv */
// Sv39 geometry constants shared by every block of the data MMU
package mmu_cfg_pkg;

    // ------------------------------
    // address widths
    // ------------------------------
    // virtual address, upper bits of the 64-bit register are sign copies and not carried
    localparam int unsigned VLEN = 39;
    // physical address
    localparam int unsigned PLEN = 56;
    // physical page number as held in a PTE
    localparam int unsigned PPNW = 44;

    // ------------------------------
    // page table geometry
    // ------------------------------
    // one VPN slice per level
    localparam int unsigned VPNW = 9;
    // 4 KiB base page
    localparam int unsigned PG_OFFSET_W = 12;
    // walk starts at level 2, leaves may sit at any level
    localparam int unsigned PT_LEVELS = 3;
    // size of one PTE in memory
    localparam int unsigned PTE_BYTES = 8;

endpackage

/* mmu_types_pkg.sv */
// PTE layout and the enums for privilege, page size, fault cause and walker state
package mmu_types_pkg;
    import mmu_cfg_pkg::*;

    // ------------------------------
    // page table entry
    // ------------------------------
    // field order follows the Sv39 PTE, v in bit 0
    typedef struct packed {
        logic [9:0]      reserved;
        logic [PPNW-1:0] ppn;
        // free for software use
        logic [1:0]      rsw;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // privilege level of the load/store access, encoding as in mstatus.MPP
    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_S = 2'b01,
        PRIV_LVL_M = 2'b11
    } priv_lvl_e;

    // page size of a TLB entry, follows the level the leaf was found at
    typedef enum logic [1:0] {
        PG_4K = 2'd0,
        PG_2M = 2'd1,
        PG_1G = 2'd2
    } pg_size_e;

    // mcause codes of the faults this unit can raise
    typedef enum logic [3:0] {
        NONE             = 4'd0,
        LOAD_PAGE_FAULT  = 4'd13,
        STORE_PAGE_FAULT = 4'd15
    } fault_cause_e;

    // walker FSM states
    typedef enum logic [1:0] {
        IDLE,
        WAIT_GRANT,
        WAIT_RVALID,
        PROPAGATE_ERROR
    } ptw_state_e;

endpackage

/* dtlb.sv */
// fully associative data TLB for 4K, 2M and 1G pages with round-robin refill
module dtlb
    import mmu_cfg_pkg::*;
    import mmu_types_pkg::*;
#(
    parameter int unsigned DTLB_ENTRIES = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // drops every entry
    input  logic                      flush_i,
    // refill from the walker
    input  logic                      update_valid_i,
    input  logic [PT_LEVELS*VPNW-1:0] update_vpn_i,
    input  pg_size_e                  update_size_i,
    input  pte_t                      update_pte_i,
    // combinational lookup
    input  logic [VLEN-1:0]           lu_vaddr_i,
    output logic                      lu_hit_o,
    output pte_t                      lu_pte_o,
    output pg_size_e                  lu_size_o
);

    localparam int unsigned IDX_W = $clog2(DTLB_ENTRIES);

    // entry storage
    logic [DTLB_ENTRIES-1:0] valid_q;
    logic [VPNW-1:0]         vpn2_q [DTLB_ENTRIES];
    logic [VPNW-1:0]         vpn1_q [DTLB_ENTRIES];
    logic [VPNW-1:0]         vpn0_q [DTLB_ENTRIES];
    pg_size_e                size_q [DTLB_ENTRIES];
    pte_t                    pte_q  [DTLB_ENTRIES];

    // replacement
    logic [IDX_W-1:0] rr_q;
    logic [IDX_W-1:0] repl_idx;
    logic             found_free;

    // VPN slices of the lookup address
    logic [VPNW-1:0] lu_vpn2;
    logic [VPNW-1:0] lu_vpn1;
    logic [VPNW-1:0] lu_vpn0;

    assign lu_vpn0 = lu_vaddr_i[PG_OFFSET_W +: VPNW];
    assign lu_vpn1 = lu_vaddr_i[PG_OFFSET_W + VPNW +: VPNW];
    assign lu_vpn2 = lu_vaddr_i[PG_OFFSET_W + 2*VPNW +: VPNW];

    // ------------------------------
    // lookup
    // ------------------------------
    // superpages ignore the lower slices, lowest matching index wins
    always_comb begin : lookup
        logic match;
        lu_hit_o  = 1'b0;
        lu_pte_o  = '0;
        lu_size_o = PG_4K;
        for (int unsigned i = 0; i < DTLB_ENTRIES; i++) begin
            match = valid_q[i] && (vpn2_q[i] == lu_vpn2);
            if (size_q[i] != PG_1G) begin
                match = match && (vpn1_q[i] == lu_vpn1);
            end
            if (size_q[i] == PG_4K) begin
                match = match && (vpn0_q[i] == lu_vpn0);
            end
            if (match && !lu_hit_o) begin
                lu_hit_o  = 1'b1;
                lu_pte_o  = pte_q[i];
                lu_size_o = size_q[i];
            end
        end
    end

    // ------------------------------
    // victim selection
    // ------------------------------
    // first free slot, else the round-robin pointer
    always_comb begin : victim
        found_free = 1'b0;
        repl_idx   = rr_q;
        for (int unsigned i = 0; i < DTLB_ENTRIES; i++) begin
            if (!valid_q[i] && !found_free) begin
                found_free = 1'b1;
                repl_idx   = IDX_W'(i);
            end
        end
    end

    // valid bits and pointer, flush wins over a refill on the same edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (update_valid_i) begin
            valid_q[repl_idx] <= 1'b1;
            // wrap explicitly, entry count need not be a power of two
            rr_q <= (rr_q == IDX_W'(DTLB_ENTRIES - 1)) ? '0 : rr_q + 1'b1;
        end
    end

    // entry payload
    always_ff @(posedge clk_i) begin
        if (update_valid_i) begin
            vpn2_q[repl_idx] <= update_vpn_i[2*VPNW +: VPNW];
            vpn1_q[repl_idx] <= update_vpn_i[VPNW +: VPNW];
            vpn0_q[repl_idx] <= update_vpn_i[0 +: VPNW];
            size_q[repl_idx] <= update_size_i;
            pte_q[repl_idx]  <= update_pte_i;
        end
    end

endmodule

/* ptw_ctrl.sv */
// Sv39 page table walker, fetches PTEs over the read port and refills the TLB or faults
module ptw_ctrl
    import mmu_cfg_pkg::*;
    import mmu_types_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      enable_translation_i,
    // miss detection
    input  logic                      lsu_req_i,
    input  logic                      dtlb_hit_i,
    input  logic [VLEN-1:0]           lsu_vaddr_i,
    // root table
    input  logic [PPNW-1:0]           satp_ppn_i,
    // memory read port
    output logic                      mem_req_o,
    output logic [PLEN-1:0]           mem_addr_o,
    input  logic                      mem_gnt_i,
    input  logic                      mem_rvalid_i,
    input  pte_t                      mem_rdata_i,
    // TLB refill
    output logic                      update_valid_o,
    output logic [PT_LEVELS*VPNW-1:0] update_vpn_o,
    output pg_size_e                  update_size_o,
    output pte_t                      update_pte_o,
    // status for the load/store stage
    output logic                      ptw_active_o,
    output logic                      ptw_error_o,
    output logic                      dtlb_miss_o
);

    localparam int unsigned LVL_W = $clog2(PT_LEVELS);

    ptw_state_e       state_q;
    ptw_state_e       state_d;
    logic [LVL_W-1:0] level_q;
    logic [LVL_W-1:0] level_d;
    // flush seen while a read was in flight
    logic             flush_q;
    logic             flush_d;
    logic [PPNW-1:0]  base_q;
    logic [PPNW-1:0]  base_d;
    logic [VLEN-1:0]  vaddr_q;
    logic [VLEN-1:0]  vaddr_d;

    logic [VPNW-1:0]  vpn_slice;
    logic             is_leaf;
    logic             misaligned;
    logic             bad_pte;

    // ------------------------------
    // PTE address
    // ------------------------------
    // base * 4096 + vpn[level] * 8
    assign vpn_slice  = vaddr_q[PG_OFFSET_W + level_q*VPNW +: VPNW];
    assign mem_addr_o = {base_q, PG_OFFSET_W'(vpn_slice) * PG_OFFSET_W'(PTE_BYTES)};
    // address is held while the grant is low
    assign mem_req_o  = (state_q == WAIT_GRANT);

    assign ptw_active_o = (state_q != IDLE);
    assign ptw_error_o  = (state_q == PROPAGATE_ERROR);

    // ------------------------------
    // PTE checks
    // ------------------------------
    assign is_leaf = mem_rdata_i.r || mem_rdata_i.x;

    // superpage leaf needs its lower PPN slices clear
    always_comb begin : superpage_check
        case (level_q)
            LVL_W'(2): misaligned = |mem_rdata_i.ppn[2*VPNW-1:0];
            LVL_W'(1): misaligned = |mem_rdata_i.ppn[VPNW-1:0];
            default:   misaligned = 1'b0;
        endcase
    end

    assign bad_pte = !mem_rdata_i.v
                  || (mem_rdata_i.w && !mem_rdata_i.r)
                  || (is_leaf && (!mem_rdata_i.a || misaligned))
                  || (!is_leaf && (level_q == '0));

    // refill fields, size follows the level the leaf was found at
    assign update_vpn_o = vaddr_q[VLEN-1:PG_OFFSET_W];
    assign update_pte_o = mem_rdata_i;

    always_comb begin : leaf_size
        case (level_q)
            LVL_W'(2): update_size_o = PG_1G;
            LVL_W'(1): update_size_o = PG_2M;
            default:   update_size_o = PG_4K;
        endcase
    end

    // ------------------------------
    // walk FSM
    // ------------------------------
    always_comb begin : walk_fsm
        state_d        = state_q;
        level_d        = level_q;
        base_d         = base_q;
        vaddr_d        = vaddr_q;
        flush_d        = flush_q || (flush_i && (state_q != IDLE));
        update_valid_o = 1'b0;
        dtlb_miss_o    = 1'b0;

        case (state_q)
            IDLE: begin
                flush_d = 1'b0;
                // miss on a translated access starts a walk from the root
                if (lsu_req_i && enable_translation_i && !dtlb_hit_i) begin
                    dtlb_miss_o = 1'b1;
                    state_d     = WAIT_GRANT;
                    level_d     = LVL_W'(PT_LEVELS - 1);
                    base_d      = satp_ppn_i;
                    vaddr_d     = lsu_vaddr_i;
                end
            end
            WAIT_GRANT: begin
                if (mem_gnt_i) begin
                    state_d = WAIT_RVALID;
                end
            end
            WAIT_RVALID: begin
                if (mem_rvalid_i) begin
                    if (flush_q || flush_i) begin
                        // stale walk, drop the result
                        state_d = IDLE;
                    end else if (bad_pte) begin
                        state_d = PROPAGATE_ERROR;
                    end else if (is_leaf) begin
                        update_valid_o = 1'b1;
                        state_d        = IDLE;
                    end else begin
                        // pointer, descend one level
                        level_d = level_q - 1'b1;
                        base_d  = mem_rdata_i.ppn;
                        state_d = WAIT_GRANT;
                    end
                end
            end
            PROPAGATE_ERROR: state_d = IDLE;
            default:         state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            level_q <= '0;
            flush_q <= 1'b0;
        end else begin
            state_q <= state_d;
            level_q <= level_d;
            flush_q <= flush_d;
        end
    end

    // walk payload
    always_ff @(posedge clk_i) begin
        base_q  <= base_d;
        vaddr_q <= vaddr_d;
    end

endmodule

/* lsu_xlate.sv */
// registered load/store translation stage, builds the physical address and page faults
module lsu_xlate
    import mmu_cfg_pkg::*;
    import mmu_types_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_ni,
    // request from the load/store unit, held until lsu_valid_o
    input  logic            lsu_req_i,
    input  logic [VLEN-1:0] lsu_vaddr_i,
    input  logic            lsu_is_store_i,
    // control levels
    input  logic            en_ld_st_translation_i,
    input  priv_lvl_e       ld_st_priv_lvl_i,
    input  logic            sum_i,
    input  logic            mxr_i,
    // TLB lookup result
    input  logic            dtlb_hit_i,
    input  pte_t            dtlb_pte_i,
    input  pg_size_e        dtlb_size_i,
    // walker status
    input  logic            ptw_active_i,
    input  logic            ptw_error_i,
    // cycle 0
    output logic            lsu_dtlb_hit_o,
    // cycle 1
    output logic            lsu_valid_o,
    output logic [PLEN-1:0] lsu_paddr_o,
    output logic            lsu_fault_valid_o,
    output fault_cause_e    lsu_fault_cause_o,
    output logic [VLEN-1:0] lsu_fault_tval_o
);

    logic            req_q;
    logic            hit_q;
    logic            is_store_q;
    logic [VLEN-1:0] vaddr_q;
    pte_t            pte_q;
    pg_size_e        size_q;

    logic            priv_err;
    logic            perm_fault;

    // untranslated accesses are always ready
    assign lsu_dtlb_hit_o = en_ld_st_translation_i ? dtlb_hit_i : 1'b1;

    // ------------------------------
    // request registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i;
            hit_q <= dtlb_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= lsu_vaddr_i;
        is_store_q <= lsu_is_store_i;
        pte_q      <= dtlb_pte_i;
        size_q     <= dtlb_size_i;
    end

    // ------------------------------
    // physical address
    // ------------------------------
    always_comb begin : paddr
        if (!en_ld_st_translation_i) begin
            // bare mode, zero extended
            lsu_paddr_o = PLEN'(vaddr_q);
        end else begin
            lsu_paddr_o = {pte_q.ppn, vaddr_q[PG_OFFSET_W-1:0]};
            // mega and giga pages take the lower VPN slices from the virtual address
            if (size_q != PG_4K) begin
                lsu_paddr_o[PG_OFFSET_W +: VPNW] = vaddr_q[PG_OFFSET_W +: VPNW];
            end
            if (size_q == PG_1G) begin
                lsu_paddr_o[PG_OFFSET_W + VPNW +: VPNW] = vaddr_q[PG_OFFSET_W + VPNW +: VPNW];
            end
        end
    end

    // ------------------------------
    // permission checks
    // ------------------------------
    // S mode touches a u page without SUM, or U mode a supervisor page
    assign priv_err = ((ld_st_priv_lvl_i == PRIV_LVL_S) && !sum_i && pte_q.u)
                   || ((ld_st_priv_lvl_i == PRIV_LVL_U) && !pte_q.u);

    // no hardware A/D update, so a clean page faults on store
    // MXR makes execute-only pages readable
    assign perm_fault = is_store_q ? (!pte_q.w || !pte_q.d || priv_err)
                                   : (priv_err || !(pte_q.r || (mxr_i && pte_q.x)));

    always_comb begin : result
        lsu_valid_o       = 1'b0;
        lsu_fault_valid_o = 1'b0;
        lsu_fault_cause_o = NONE;
        lsu_fault_tval_o  = '0;

        if (!en_ld_st_translation_i) begin
            lsu_valid_o = req_q;
        end else if (req_q && hit_q) begin
            lsu_valid_o       = 1'b1;
            lsu_fault_valid_o = perm_fault;
        end else if (req_q && ptw_active_i && ptw_error_i) begin
            // walker only raises page faults
            lsu_valid_o       = 1'b1;
            lsu_fault_valid_o = 1'b1;
        end

        // cause follows the kind of access
        if (lsu_fault_valid_o) begin
            lsu_fault_cause_o = is_store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
            lsu_fault_tval_o  = vaddr_q;
        end
    end

endmodule

/* mmu_top.sv */
// data side Sv39 MMU with TLB, page table walker and load/store translation stage
module mmu_top
    import mmu_cfg_pkg::*;
    import mmu_types_pkg::*;
#(
    parameter int unsigned DTLB_ENTRIES = 4
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    // load/store request
    input  logic            lsu_req_i,
    input  logic [VLEN-1:0] lsu_vaddr_i,
    input  logic            lsu_is_store_i,
    output logic            lsu_dtlb_hit_o,
    output logic            lsu_valid_o,
    output logic [PLEN-1:0] lsu_paddr_o,
    output logic            lsu_fault_valid_o,
    output fault_cause_e    lsu_fault_cause_o,
    output logic [VLEN-1:0] lsu_fault_tval_o,
    // control levels
    input  logic            en_ld_st_translation_i,
    input  priv_lvl_e       ld_st_priv_lvl_i,
    input  logic            sum_i,
    input  logic            mxr_i,
    input  logic [PPNW-1:0] satp_ppn_i,
    input  logic            flush_tlb_i,
    // PTE memory read port
    output logic            mem_req_o,
    output logic [PLEN-1:0] mem_addr_o,
    input  logic            mem_gnt_i,
    input  logic            mem_rvalid_i,
    input  pte_t            mem_rdata_i,
    // performance counter pulse
    output logic            dtlb_miss_o
);

    // lookup
    logic                      dtlb_hit;
    pte_t                      dtlb_pte;
    pg_size_e                  dtlb_size;
    // refill
    logic                      update_valid;
    logic [PT_LEVELS*VPNW-1:0] update_vpn;
    pg_size_e                  update_size;
    pte_t                      update_pte;
    // walker status
    logic                      ptw_active;
    logic                      ptw_error;

    dtlb #(
        .DTLB_ENTRIES   ( DTLB_ENTRIES )
    ) i_dtlb (
        .clk_i          ( clk_i        ),
        .rst_ni         ( rst_ni       ),
        .flush_i        ( flush_tlb_i  ),
        .update_valid_i ( update_valid ),
        .update_vpn_i   ( update_vpn   ),
        .update_size_i  ( update_size  ),
        .update_pte_i   ( update_pte   ),
        .lu_vaddr_i     ( lsu_vaddr_i  ),
        .lu_hit_o       ( dtlb_hit     ),
        .lu_pte_o       ( dtlb_pte     ),
        .lu_size_o      ( dtlb_size    )
    );

    ptw_ctrl i_ptw (
        .clk_i                ( clk_i                  ),
        .rst_ni               ( rst_ni                 ),
        .flush_i              ( flush_tlb_i            ),
        .enable_translation_i ( en_ld_st_translation_i ),
        .lsu_req_i            ( lsu_req_i              ),
        .dtlb_hit_i           ( dtlb_hit               ),
        .lsu_vaddr_i          ( lsu_vaddr_i            ),
        .satp_ppn_i           ( satp_ppn_i             ),
        .mem_req_o            ( mem_req_o              ),
        .mem_addr_o           ( mem_addr_o             ),
        .mem_gnt_i            ( mem_gnt_i              ),
        .mem_rvalid_i         ( mem_rvalid_i           ),
        .mem_rdata_i          ( mem_rdata_i            ),
        .update_valid_o       ( update_valid           ),
        .update_vpn_o         ( update_vpn             ),
        .update_size_o        ( update_size            ),
        .update_pte_o         ( update_pte             ),
        .ptw_active_o         ( ptw_active             ),
        .ptw_error_o          ( ptw_error              ),
        .dtlb_miss_o          ( dtlb_miss_o            )
    );

    lsu_xlate i_lsu_xlate (
        .clk_i                  ( clk_i                  ),
        .rst_ni                 ( rst_ni                 ),
        .lsu_req_i              ( lsu_req_i              ),
        .lsu_vaddr_i            ( lsu_vaddr_i            ),
        .lsu_is_store_i         ( lsu_is_store_i         ),
        .en_ld_st_translation_i ( en_ld_st_translation_i ),
        .ld_st_priv_lvl_i       ( ld_st_priv_lvl_i       ),
        .sum_i                  ( sum_i                  ),
        .mxr_i                  ( mxr_i                  ),
        .dtlb_hit_i             ( dtlb_hit               ),
        .dtlb_pte_i             ( dtlb_pte               ),
        .dtlb_size_i            ( dtlb_size              ),
        .ptw_active_i           ( ptw_active             ),
        .ptw_error_i            ( ptw_error              ),
        .lsu_dtlb_hit_o         ( lsu_dtlb_hit_o         ),
        .lsu_valid_o            ( lsu_valid_o            ),
        .lsu_paddr_o            ( lsu_paddr_o            ),
        .lsu_fault_valid_o      ( lsu_fault_valid_o      ),
        .lsu_fault_cause_o      ( lsu_fault_cause_o      ),
        .lsu_fault_tval_o       ( lsu_fault_tval_o       )
    );

endmodule

/* tb_mmu.sv */
// self-checking testbench for the data MMU that replays PTE images and requests from a table
module tb_mmu
    import mmu_cfg_pkg::*;
    import mmu_types_pkg::*;
();

    localparam int unsigned DTLB_ENTRIES = 4;
    // cycles one request may take before it counts as hung
    localparam int          REQ_TIMEOUT  = 200;

    // DUT ports
    logic            clk_i;
    logic            rst_ni;
    logic            lsu_req_i;
    logic [VLEN-1:0] lsu_vaddr_i;
    logic            lsu_is_store_i;
    logic            lsu_dtlb_hit_o;
    logic            lsu_valid_o;
    logic [PLEN-1:0] lsu_paddr_o;
    logic            lsu_fault_valid_o;
    fault_cause_e    lsu_fault_cause_o;
    logic [VLEN-1:0] lsu_fault_tval_o;
    logic            en_ld_st_translation_i;
    priv_lvl_e       ld_st_priv_lvl_i;
    logic            sum_i;
    logic            mxr_i;
    logic [PPNW-1:0] satp_ppn_i;
    logic            flush_tlb_i;
    logic            mem_req_o;
    logic [PLEN-1:0] mem_addr_o;
    logic            mem_gnt_i;
    logic            mem_rvalid_i;
    pte_t            mem_rdata_i;
    logic            dtlb_miss_o;

    // sparse PTE memory with address and data kept side by side
    logic [PLEN-1:0] pte_addr_q [$];
    logic [63:0]     pte_data_q [$];

    int   checks;
    int   mismatches;
    int   failures;
    int   miss_count;
    // cumulative miss count of the previous request line
    int   prev_misses;
    logic abort_run;

    mmu_top #(
        .DTLB_ENTRIES ( DTLB_ENTRIES )
    ) dut (.*);

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    // count walker starts on the rising edge where the pulse is settled
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            miss_count <= 0;
        end else if (dtlb_miss_o === 1'b1) begin
            miss_count <= miss_count + 1;
        end
    end

    // ------------------------------
    // memory model
    // ------------------------------
    // unmapped addresses read as zero and so as an invalid PTE
    function automatic logic [63:0] read_pte(input logic [PLEN-1:0] addr);
        logic [63:0] data;
        data = '0;
        foreach (pte_addr_q[i]) begin
            if (pte_addr_q[i] == addr) begin
                data = pte_data_q[i];
            end
        end
        return data;
    endfunction

    // grant after 0..2 cycles and one rvalid pulse 1..3 cycles after the grant edge
    task automatic serve_read();
        int              gnt_delay;
        int              rvalid_delay;
        logic [PLEN-1:0] addr;
        gnt_delay    = int'($urandom % 3);
        rvalid_delay = 1 + int'($urandom % 3);
        repeat (gnt_delay) @(negedge clk_i);
        addr      = mem_addr_o;
        mem_gnt_i = 1'b1;
        @(negedge clk_i);
        mem_gnt_i = 1'b0;
        repeat (rvalid_delay - 1) @(negedge clk_i);
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = pte_t'(read_pte(addr));
        @(negedge clk_i);
        mem_rvalid_i = 1'b0;
    endtask

    initial begin : memory_model
        void'($urandom(32'h39d2_d587));
        @(negedge clk_i);
        forever begin
            if (mem_req_o === 1'b1) begin
                serve_read();
            end else begin
                @(negedge clk_i);
            end
        end
    end

    // ------------------------------
    // checks and stimulus
    // ------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic set_control(input logic enable, input logic [PPNW-1:0] satp);
        @(negedge clk_i);
        en_ld_st_translation_i = enable;
        satp_ppn_i             = satp;
    endtask

    task automatic pulse_flush();
        @(negedge clk_i);
        flush_tlb_i = 1'b1;
        @(negedge clk_i);
        flush_tlb_i = 1'b0;
    endtask

    // hold the request until lsu_valid_o and then compare against the table
    task automatic run_request(input logic store, input logic [VLEN-1:0] vaddr,
                               input logic [1:0] priv, input logic sum, input logic mxr,
                               input logic [PLEN-1:0] exp_paddr, input logic [3:0] exp_cause,
                               input int exp_misses);
        int   waited;
        logic fault_exp;
        logic hit_exp;
        @(negedge clk_i);
        lsu_req_i        = 1'b1;
        lsu_vaddr_i      = vaddr;
        lsu_is_store_i   = store;
        ld_st_priv_lvl_i = priv_lvl_e'(priv);
        sum_i            = sum;
        mxr_i            = mxr;
        @(negedge clk_i);
        waited = 1;
        // a new miss in the table means the first lookup missed
        // no refill can land this early in a walk
        hit_exp = !en_ld_st_translation_i || (exp_misses == prev_misses);
        check_value("lsu_dtlb_hit_o", 64'(lsu_dtlb_hit_o), 64'(hit_exp));
        prev_misses = exp_misses;
        while (lsu_valid_o !== 1'b1 && waited < REQ_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (lsu_valid_o !== 1'b1) begin
            failures++;
            abort_run = 1'b1;
            $display("no response from the MMU within %0d cycles for vaddr %h",
                     REQ_TIMEOUT, vaddr);
        end else begin
            // a fault always reports the virtual address as tval
            fault_exp = (exp_cause != 4'd0);
            if (!fault_exp) begin
                check_value("lsu_paddr_o", 64'(lsu_paddr_o), 64'(exp_paddr));
            end
            check_value("lsu_fault_valid_o", 64'(lsu_fault_valid_o), 64'(fault_exp));
            check_value("lsu_fault_cause_o", 64'(lsu_fault_cause_o), 64'(exp_cause));
            check_value("lsu_fault_tval_o", 64'(lsu_fault_tval_o),
                        fault_exp ? 64'(vaddr) : 64'd0);
            check_value("dtlb_miss_o count", 64'(miss_count), 64'(exp_misses));
        end
        lsu_req_i = 1'b0;
    endtask

    // the first character of a table line selects its kind
    task automatic run_line(input string line);
        byte         kind;
        int          n;
        logic [63:0] fld [8];
        kind = line.getc(0);
        case (kind)
            "M": begin
                n = $sscanf(line, "M %h %h", fld[0], fld[1]);
                pte_addr_q.push_back(fld[0][PLEN-1:0]);
                pte_data_q.push_back(fld[1]);
            end
            "C": begin
                n = $sscanf(line, "C %h %h", fld[0], fld[1]);
                set_control(fld[0][0], fld[1][PPNW-1:0]);
            end
            "F": begin
                n = 2;
                pulse_flush();
            end
            "R": begin
                n = $sscanf(line, "R %h %h %h %h %h %h %h %d", fld[0], fld[1], fld[2],
                            fld[3], fld[4], fld[5], fld[6], fld[7]);
                if (n == 8) begin
                    run_request(fld[0][0], fld[1][VLEN-1:0], fld[2][1:0], fld[3][0],
                                fld[4][0], fld[5][PLEN-1:0], fld[6][3:0], int'(fld[7]));
                end
            end
            // comments and blank lines
            default: n = -1;
        endcase
        if (n >= 0 && n != 2 && n != 8) begin
            failures++;
            $display("malformed line in the test file: %s", line);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, value mismatches %0d, other failures %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0 && checks > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin : main
        int    fd;
        string line;
        checks                 = 0;
        mismatches             = 0;
        failures               = 0;
        prev_misses            = 0;
        abort_run              = 1'b0;
        rst_ni                 = 1'b0;
        lsu_req_i              = 1'b0;
        lsu_vaddr_i            = '0;
        lsu_is_store_i         = 1'b0;
        en_ld_st_translation_i = 1'b0;
        ld_st_priv_lvl_i       = PRIV_LVL_S;
        sum_i                  = 1'b0;
        mxr_i                  = 1'b0;
        satp_ppn_i             = '0;
        flush_tlb_i            = 1'b0;
        mem_gnt_i              = 1'b0;
        mem_rvalid_i           = 1'b0;
        mem_rdata_i            = '0;
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;

        fd = $fopen("mmu_tests.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("cannot open the test file mmu_tests.txt");
        end else begin
            while (!abort_run && !$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    run_line(line);
                end
            end
            $fclose(fd);
        end
        finish_run();
    end

endmodule

/* mmu_tests.txt */
# M pte_addr pte_data | C enable satp_ppn | F (flush whole TLB)
# R store vaddr priv sum mxr exp_paddr exp_cause exp_misses (all hex but exp_misses, decimal)
# root table at ppn 80000, level 1 table at 80001, level 0 table at 80002
M 80000008 20000401
M 80000010 300000c7
M 80001010 20000801
M 80001028 100800c7
M 80001030 100804c7
M 80002018 048d14c7
M 80002020 048d18c3
M 80002028 048d1c47
M 80002030 048d20d7
M 80002038 048d2449
M 80002040 048d2806
M 80002048 20000801
# bare mode, address passes through
C 0 80000
R 0 40403234 1 0 0 40403234 0 0
R 1 7fffffffff 3 0 0 7fffffffff 0 0
# three level walk, then a hit
C 1 80000
R 0 40403234 1 0 0 12345234 0 1
R 1 40403238 1 0 0 12345238 0 1
# 2M and 1G leaves
R 0 40bab456 1 0 0 403ab456 0 2
R 0 956cd789 1 0 0 d56cd789 0 3
# read-only page, dirty clear page, user page, execute-only page
R 0 40404010 1 0 0 12346010 0 4
R 1 40404010 1 0 0 0 f 4
R 0 40405020 1 0 0 12347020 0 5
R 1 40405020 1 0 0 0 f 5
R 0 40405024 0 0 0 0 d 5
R 0 40406030 1 0 0 0 d 6
R 0 40406030 1 1 0 12348030 0 6
R 1 40406034 0 0 0 12348034 0 6
R 0 40407040 1 0 0 0 d 7
R 0 40407040 1 0 1 12349040 0 7
# walker faults, invalid PTE, misaligned 2M leaf, pointer at level 0
R 1 40408000 1 0 0 0 f 8
R 0 40c00100 1 0 0 0 d 9
R 0 40409000 1 0 0 0 d 10
# flush, earlier pages walk again
F
R 0 40403234 1 0 0 12345234 0 11
R 1 40403234 1 0 0 12345234 0 11
R 0 956cd789 1 0 0 d56cd789 0 12

/* all.f */
mmu_cfg_pkg.sv
mmu_types_pkg.sv
dtlb.sv
ptw_ctrl.sv
lsu_xlate.sv
mmu_top.sv
tb_mmu.sv

/* Makefile */
# Verilator build and run of the data MMU testbench
VERILATOR ?= verilator
TOP       ?= tb_mmu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
